/* source/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////
	// bus widths
	//////////////////////////////

	localparam int ADDR_BITS  = 64;
	localparam int DATA_BITS  = 64;
	localparam int CU_ID_BITS = 4;
	localparam int COUNT_BITS = 32;

	// one queued read command is the address with the cu id below it
	localparam int CMD_BITS = ADDR_BITS + CU_ID_BITS;

	//////////////////////////////
	// compute-unit ids
	//////////////////////////////

	localparam logic [CU_ID_BITS-1:0] VERTEX_CONTROL_ID    = 4'd0;
	localparam logic [CU_ID_BITS-1:0] ALGORITHM_CONTROL_ID = 4'd1;

	//////////////////////////////
	// buffer sizes
	//////////////////////////////

	// per-source command queues
	localparam int READ_CMD_BUFFER_SIZE = 8;

	// burst buffer ahead of the read command port
	localparam int BURST_BUFFER_SIZE = 16;
	localparam int BURST_HEADROOM    = 8;

	//////////////////////////////
	// vector types
	//////////////////////////////

	typedef logic [ADDR_BITS-1:0]  addr_t;
	typedef logic [DATA_BITS-1:0]  data_t;
	typedef logic [CU_ID_BITS-1:0] cu_id_t;
	typedef logic [COUNT_BITS-1:0] count_t;

	// edges done in the upper half, vertex total in the lower half
	typedef logic [63:0] status_t;

	// one bit per pending algorithm request
	typedef logic [63:0] request_t;

endpackage

`default_nettype wire

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 8,
	parameter int HEADROOM = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             almost_full,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int FILL_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [PTR_BITS-1:0]  wr_ptr;
	logic [PTR_BITS-1:0]  rd_ptr;
	logic [FILL_BITS-1:0] fill;
	logic                 do_push;
	logic                 do_pop;

	// wrap at DEPTH so non power of two sizes work
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// a push into a full queue or a pop from an empty one is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// show-ahead: head entry always on the output
	assign data_out    = mem[rd_ptr];
	assign empty       = (fill == '0);
	assign full        = (fill == FILL_BITS'(DEPTH));
	assign almost_full = (fill >= FILL_BITS'(DEPTH - HEADROOM));

endmodule

`default_nettype wire

/* source/read_command_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_command_arbiter (
	input  logic            clock,
	input  logic            rstn,
	input  logic            vertex_empty,
	input  logic            algorithm_empty,
	input  cu_pkg::addr_t   vertex_address,
	input  cu_pkg::cu_id_t  vertex_cu_id,
	input  cu_pkg::addr_t   algorithm_address,
	input  cu_pkg::cu_id_t  algorithm_cu_id,
	input  logic            burst_almost_full,
	input  logic            read_buffer_alfull,
	output logic            vertex_pop,
	output logic            algorithm_pop,
	output logic            grant_valid,
	output cu_pkg::addr_t   grant_address,
	output cu_pkg::cu_id_t  grant_cu_id,
	input  logic            burst_empty,
	input  cu_pkg::addr_t   burst_address,
	input  cu_pkg::cu_id_t  burst_cu_id,
	output logic            burst_pop,
	output logic            read_command_valid,
	output cu_pkg::addr_t   read_command_address,
	output cu_pkg::cu_id_t  read_command_cu_id
);

	import cu_pkg::*;

	logic vertex_request;
	logic algorithm_request;
	logic vertex_win;
	logic algorithm_win;
	// set when the algorithm queue won the last grant
	logic last_algorithm;

	//////////////////////////////
	// queue arbitration
	//////////////////////////////

	assign vertex_request    = !vertex_empty && !burst_almost_full && !read_buffer_alfull;
	assign algorithm_request = !algorithm_empty && !burst_almost_full && !read_buffer_alfull;

	// on a tie the side not granted last wins
	assign vertex_win    = vertex_request && (!algorithm_request || last_algorithm);
	assign algorithm_win = algorithm_request && (!vertex_request || !last_algorithm);

	assign vertex_pop    = vertex_win;
	assign algorithm_pop = algorithm_win;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// first tie after reset goes to the vertex side
			last_algorithm <= 1'b1;
			grant_valid    <= 1'b0;
		end else begin
			grant_valid <= vertex_win || algorithm_win;
			if (vertex_win || algorithm_win) begin
				last_algorithm <= algorithm_win;
			end
		end
	end

	always_ff @(posedge clock) begin
		grant_address <= vertex_win ? vertex_address : algorithm_address;
		grant_cu_id   <= vertex_win ? vertex_cu_id : algorithm_cu_id;
	end

	//////////////////////////////
	// burst buffer output stage
	//////////////////////////////

	assign burst_pop = !burst_empty && !read_buffer_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid <= 1'b0;
		end else begin
			read_command_valid <= burst_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (burst_pop) begin
			read_command_address <= burst_address;
			read_command_cu_id   <= burst_cu_id;
		end
	end

endmodule

`default_nettype wire

/* source/response_router.sv */
`timescale 1ns/1ps
`default_nettype none

module response_router (
	input  logic           clock,
	input  logic           rstn,
	input  logic           read_response_valid,
	input  cu_pkg::cu_id_t read_response_cu_id,
	input  logic           read_data_valid,
	input  cu_pkg::cu_id_t read_data_cu_id,
	input  cu_pkg::data_t  read_data,
	output logic           vertex_response_valid,
	output logic           algorithm_response_valid,
	output logic           vertex_data_valid,
	output logic           algorithm_data_valid,
	output cu_pkg::data_t  vertex_data,
	output cu_pkg::data_t  algorithm_data
);

	import cu_pkg::*;

	logic   response_valid_q;
	cu_id_t response_cu_id_q;
	logic   data_valid_q;
	cu_id_t data_cu_id_q;
	data_t  data_q;
	logic   response_to_vertex;
	logic   data_to_vertex;

	//////////////////////////////
	// input register stage
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_valid_q <= 1'b0;
			data_valid_q     <= 1'b0;
		end else begin
			response_valid_q <= read_response_valid;
			data_valid_q     <= read_data_valid;
		end
	end

	always_ff @(posedge clock) begin
		response_cu_id_q <= read_response_cu_id;
		data_cu_id_q     <= read_data_cu_id;
		data_q           <= read_data;
	end

	//////////////////////////////
	// steering stage
	//////////////////////////////

	// only the vertex id goes to the vertex side, all others to the algorithm
	assign response_to_vertex = (response_cu_id_q == VERTEX_CONTROL_ID);
	assign data_to_vertex     = (data_cu_id_q == VERTEX_CONTROL_ID);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_response_valid    <= 1'b0;
			algorithm_response_valid <= 1'b0;
			vertex_data_valid        <= 1'b0;
			algorithm_data_valid     <= 1'b0;
		end else begin
			vertex_response_valid    <= response_valid_q && response_to_vertex;
			algorithm_response_valid <= response_valid_q && !response_to_vertex;
			vertex_data_valid        <= data_valid_q && data_to_vertex;
			algorithm_data_valid     <= data_valid_q && !data_to_vertex;
		end
	end

	// side not chosen sees zero data
	always_ff @(posedge clock) begin
		vertex_data    <= (data_valid_q && data_to_vertex) ? data_q : '0;
		algorithm_data <= (data_valid_q && !data_to_vertex) ? data_q : '0;
	end

endmodule

`default_nettype wire

/* source/completion_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module completion_monitor (
	input  logic             clock,
	input  logic             rstn,
	input  logic             wed_valid,
	input  cu_pkg::count_t   num_vertices,
	input  cu_pkg::count_t   num_edges,
	input  cu_pkg::count_t   vertex_filtered_count,
	input  cu_pkg::count_t   vertex_done_count,
	input  cu_pkg::count_t   edge_done_count,
	input  cu_pkg::request_t algorithm_requests,
	output cu_pkg::status_t  algorithm_status,
	output logic             algorithm_running
);

	import cu_pkg::*;

	logic     wed_valid_q;
	count_t   num_vertices_q;
	count_t   num_edges_q;
	count_t   filtered_q;
	count_t   vertex_done_q;
	count_t   edge_done_q;
	request_t requests_q;
	count_t   vertex_total;
	logic     job_done;

	always_ff @(posedge clock) begin
		num_vertices_q <= num_vertices;
		num_edges_q    <= num_edges;
		filtered_q     <= vertex_filtered_count;
		vertex_done_q  <= vertex_done_count;
		edge_done_q    <= edge_done_count;
	end

	// filtered vertices count as finished
	assign vertex_total = filtered_q + vertex_done_q;
	assign job_done     = wed_valid_q && (num_vertices_q == vertex_total)
		&& (num_edges_q == edge_done_q);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_valid_q       <= 1'b0;
			requests_q        <= '0;
			algorithm_status  <= '0;
			algorithm_running <= 1'b0;
		end else begin
			wed_valid_q <= wed_valid;
			// mask is sticky, a zero mask never clears it
			if (|algorithm_requests) begin
				requests_q <= algorithm_requests;
			end
			algorithm_status  <= job_done ? {edge_done_q, vertex_total} : '0;
			algorithm_running <= |requests_q;
		end
	end

endmodule

`default_nettype wire

/* source/cu_control_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control_top (
	input  logic             clock,
	input  logic             rstn,
	input  logic             vertex_cmd_valid,
	input  cu_pkg::addr_t    vertex_cmd_address,
	input  cu_pkg::cu_id_t   vertex_cmd_cu_id,
	output logic             vertex_cmd_full,
	input  logic             algorithm_cmd_valid,
	input  cu_pkg::addr_t    algorithm_cmd_address,
	input  cu_pkg::cu_id_t   algorithm_cmd_cu_id,
	output logic             algorithm_cmd_full,
	input  logic             read_buffer_alfull,
	output logic             read_command_valid,
	output cu_pkg::addr_t    read_command_address,
	output cu_pkg::cu_id_t   read_command_cu_id,
	input  logic             read_response_valid,
	input  cu_pkg::cu_id_t   read_response_cu_id,
	input  logic             read_data_valid,
	input  cu_pkg::cu_id_t   read_data_cu_id,
	input  cu_pkg::data_t    read_data,
	output logic             vertex_response_valid,
	output logic             algorithm_response_valid,
	output logic             vertex_data_valid,
	output logic             algorithm_data_valid,
	output cu_pkg::data_t    vertex_data,
	output cu_pkg::data_t    algorithm_data,
	input  logic             wed_valid,
	input  cu_pkg::count_t   num_vertices,
	input  cu_pkg::count_t   num_edges,
	input  cu_pkg::count_t   vertex_filtered_count,
	input  cu_pkg::count_t   vertex_done_count,
	input  cu_pkg::count_t   edge_done_count,
	input  cu_pkg::request_t algorithm_requests,
	output cu_pkg::status_t  algorithm_status,
	output logic             algorithm_running
);

	import cu_pkg::*;

	logic [CMD_BITS-1:0] vertex_head;
	logic [CMD_BITS-1:0] algorithm_head;
	logic [CMD_BITS-1:0] burst_head;
	logic                vertex_empty;
	logic                algorithm_empty;
	logic                vertex_pop;
	logic                algorithm_pop;
	logic                grant_valid;
	addr_t               grant_address;
	cu_id_t              grant_cu_id;
	logic                burst_almost_full;
	logic                burst_empty;
	logic                burst_pop;

	//////////////////////////////
	// per-source command queues
	//////////////////////////////

	sync_fifo #(.WIDTH(CMD_BITS), .DEPTH(READ_CMD_BUFFER_SIZE)) vertex_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (vertex_cmd_valid),
		.data_in    ({vertex_cmd_address, vertex_cmd_cu_id}),
		.full       (vertex_cmd_full),
		.almost_full(),
		.pop        (vertex_pop),
		.data_out   (vertex_head),
		.empty      (vertex_empty)
	);

	sync_fifo #(.WIDTH(CMD_BITS), .DEPTH(READ_CMD_BUFFER_SIZE)) algorithm_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (algorithm_cmd_valid),
		.data_in    ({algorithm_cmd_address, algorithm_cmd_cu_id}),
		.full       (algorithm_cmd_full),
		.almost_full(),
		.pop        (algorithm_pop),
		.data_out   (algorithm_head),
		.empty      (algorithm_empty)
	);

	//////////////////////////////
	// arbiter and burst buffer
	//////////////////////////////

	read_command_arbiter read_command_arbiter (
		.clock               (clock),
		.rstn                (rstn),
		.vertex_empty        (vertex_empty),
		.algorithm_empty     (algorithm_empty),
		.vertex_address      (vertex_head[CMD_BITS-1:CU_ID_BITS]),
		.vertex_cu_id        (vertex_head[CU_ID_BITS-1:0]),
		.algorithm_address   (algorithm_head[CMD_BITS-1:CU_ID_BITS]),
		.algorithm_cu_id     (algorithm_head[CU_ID_BITS-1:0]),
		.burst_almost_full   (burst_almost_full),
		.read_buffer_alfull  (read_buffer_alfull),
		.vertex_pop          (vertex_pop),
		.algorithm_pop       (algorithm_pop),
		.grant_valid         (grant_valid),
		.grant_address       (grant_address),
		.grant_cu_id         (grant_cu_id),
		.burst_empty         (burst_empty),
		.burst_address       (burst_head[CMD_BITS-1:CU_ID_BITS]),
		.burst_cu_id         (burst_head[CU_ID_BITS-1:0]),
		.burst_pop           (burst_pop),
		.read_command_valid  (read_command_valid),
		.read_command_address(read_command_address),
		.read_command_cu_id  (read_command_cu_id)
	);

	// almost-full leaves headroom for commands still in flight
	sync_fifo #(
		.WIDTH   (CMD_BITS),
		.DEPTH   (BURST_BUFFER_SIZE),
		.HEADROOM(BURST_HEADROOM)
	) burst_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (grant_valid),
		.data_in    ({grant_address, grant_cu_id}),
		.full       (),
		.almost_full(burst_almost_full),
		.pop        (burst_pop),
		.data_out   (burst_head),
		.empty      (burst_empty)
	);

	//////////////////////////////
	// responses and completion
	//////////////////////////////

	response_router response_router (
		.clock                   (clock),
		.rstn                    (rstn),
		.read_response_valid     (read_response_valid),
		.read_response_cu_id     (read_response_cu_id),
		.read_data_valid         (read_data_valid),
		.read_data_cu_id         (read_data_cu_id),
		.read_data               (read_data),
		.vertex_response_valid   (vertex_response_valid),
		.algorithm_response_valid(algorithm_response_valid),
		.vertex_data_valid       (vertex_data_valid),
		.algorithm_data_valid    (algorithm_data_valid),
		.vertex_data             (vertex_data),
		.algorithm_data          (algorithm_data)
	);

	completion_monitor completion_monitor (
		.clock                (clock),
		.rstn                 (rstn),
		.wed_valid            (wed_valid),
		.num_vertices         (num_vertices),
		.num_edges            (num_edges),
		.vertex_filtered_count(vertex_filtered_count),
		.vertex_done_count    (vertex_done_count),
		.edge_done_count      (edge_done_count),
		.algorithm_requests   (algorithm_requests),
		.algorithm_status     (algorithm_status),
		.algorithm_running    (algorithm_running)
	);

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// reset released on a rising edge, like any other driven input
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/tb_cu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cu_control;

	import cu_pkg::*;

	localparam int CLOCK_PERIOD     = 8;
	localparam int RESET_CYCLES     = 10;
	localparam int FAIR_DEPTH       = 8;
	localparam int TRAFFIC_PUSHES   = 150;
	localparam int ROUTING_BEATS    = 200;
	localparam int COMPLETION_STEPS = 120;

	// summed cycle budget of all tests
	localparam int TEST_CYCLES = (RESET_CYCLES + 4) + (4 * FAIR_DEPTH + 40)
		+ (8 * TRAFFIC_PUSHES + 100) + (ROUTING_BEATS + 10) + (COMPLETION_STEPS + 20);
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLOCK_PERIOD;

	logic     clock;
	logic     rstn;
	logic     vertex_cmd_valid;
	addr_t    vertex_cmd_address;
	cu_id_t   vertex_cmd_cu_id;
	logic     vertex_cmd_full;
	logic     algorithm_cmd_valid;
	addr_t    algorithm_cmd_address;
	cu_id_t   algorithm_cmd_cu_id;
	logic     algorithm_cmd_full;
	logic     read_buffer_alfull;
	logic     read_command_valid;
	addr_t    read_command_address;
	cu_id_t   read_command_cu_id;
	logic     read_response_valid;
	cu_id_t   read_response_cu_id;
	logic     read_data_valid;
	cu_id_t   read_data_cu_id;
	data_t    read_data;
	logic     vertex_response_valid;
	logic     algorithm_response_valid;
	logic     vertex_data_valid;
	logic     algorithm_data_valid;
	data_t    vertex_data;
	data_t    algorithm_data;
	logic     wed_valid;
	count_t   num_vertices;
	count_t   num_edges;
	count_t   vertex_filtered_count;
	count_t   vertex_done_count;
	count_t   edge_done_count;
	request_t algorithm_requests;
	status_t  algorithm_status;
	logic     algorithm_running;

	// reference model
	addr_t    vertex_expected[$];
	addr_t    algorithm_expected[$];
	logic     fairness_active;
	cu_id_t   fairness_next_id;
	int       fairness_seen;
	int       error_count;
	int       tests_run;
	int       tests_passed;
	int       seed_value;
	logic     response_for_vertex;
	logic     response_for_algorithm;
	logic     data_for_vertex;
	logic     data_for_algorithm;
	status_t  status_now;

	clock_gen #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen0 (
		.clock(clock),
		.rstn (rstn)
	);

	cu_control_top dut0 (.*);

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic note_failure(input string message);
		error_count++;
		$display("ERROR %0t: %s", $time, message);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	function automatic addr_t random_address();
		return {$urandom, $urandom};
	endfunction

	// half the beats target the vertex side
	function automatic cu_id_t random_cu_id();
		if (($urandom % 2) == 1) begin
			return VERTEX_CONTROL_ID;
		end
		return cu_id_t'($urandom);
	endfunction

	// status word as the descriptor rules define it
	function automatic status_t expected_status(input logic valid, input count_t vertices_total,
			input count_t edges_total, input count_t filtered, input count_t vertices_done,
			input count_t edges_done);
		count_t finished;
		finished = filtered + vertices_done;
		if (valid && (vertices_total == finished) && (edges_total == edges_done)) begin
			return {edges_done, finished};
		end
		return '0;
	endfunction

	task automatic push_vertex(input addr_t address);
		vertex_cmd_valid   <= 1'b1;
		vertex_cmd_address <= address;
		vertex_cmd_cu_id   <= VERTEX_CONTROL_ID;
		vertex_expected.push_back(address);
	endtask

	task automatic push_algorithm(input addr_t address);
		algorithm_cmd_valid   <= 1'b1;
		algorithm_cmd_address <= address;
		algorithm_cmd_cu_id   <= ALGORITHM_CONTROL_ID;
		algorithm_expected.push_back(address);
	endtask

	task automatic wait_for_drain();
		while (vertex_expected.size() != 0 || algorithm_expected.size() != 0) begin
			@(posedge clock);
		end
		// idle cycles to catch any extra command
		repeat (8) @(posedge clock);
	endtask

	task automatic expect_low(input logic value, input string name);
		assert (value == 1'b0) else note_failure($sformatf("%s not low after reset", name));
	endtask

	//////////////////////////////
	// command scoreboard
	//////////////////////////////

	always @(posedge clock) begin
		addr_t expected;
		if (rstn && read_command_valid) begin
			if (fairness_active) begin
				assert (read_command_cu_id == fairness_next_id)
					else note_failure($sformatf("arbiter gave cu_id %0d, expected %0d",
						read_command_cu_id, fairness_next_id));
				fairness_next_id = (read_command_cu_id == VERTEX_CONTROL_ID)
					? ALGORITHM_CONTROL_ID : VERTEX_CONTROL_ID;
				fairness_seen++;
			end
			if (read_command_cu_id == VERTEX_CONTROL_ID && vertex_expected.size() != 0) begin
				expected = vertex_expected.pop_front();
				assert (read_command_address == expected)
					else note_failure($sformatf("vertex address %h, expected %h",
						read_command_address, expected));
			end else if (read_command_cu_id == ALGORITHM_CONTROL_ID
					&& algorithm_expected.size() != 0) begin
				expected = algorithm_expected.pop_front();
				assert (read_command_address == expected)
					else note_failure($sformatf("algorithm address %h, expected %h",
						read_command_address, expected));
			end else begin
				note_failure($sformatf("command with cu_id %0d matches no pending push",
					read_command_cu_id));
			end
		end
	end

	//////////////////////////////
	// concurrent checks
	//////////////////////////////

	assign response_for_vertex    = read_response_valid
		&& (read_response_cu_id == VERTEX_CONTROL_ID);
	assign response_for_algorithm = read_response_valid
		&& (read_response_cu_id != VERTEX_CONTROL_ID);
	assign data_for_vertex        = read_data_valid && (read_data_cu_id == VERTEX_CONTROL_ID);
	assign data_for_algorithm     = read_data_valid && (read_data_cu_id != VERTEX_CONTROL_ID);
	assign status_now = expected_status(wed_valid, num_vertices, num_edges,
		vertex_filtered_count, vertex_done_count, edge_done_count);

	backpressure_held: assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_alfull |=> !read_command_valid)
		else note_failure("read command issued after read_buffer_alfull");

	vertex_response_routed: assert property (@(posedge clock) disable iff (!rstn)
		vertex_response_valid == $past(response_for_vertex, 2))
		else note_failure("vertex_response_valid wrong");

	algorithm_response_routed: assert property (@(posedge clock) disable iff (!rstn)
		algorithm_response_valid == $past(response_for_algorithm, 2))
		else note_failure("algorithm_response_valid wrong");

	vertex_data_routed: assert property (@(posedge clock) disable iff (!rstn)
		(vertex_data_valid == $past(data_for_vertex, 2))
		&& (vertex_data == ($past(data_for_vertex, 2) ? $past(read_data, 2) : '0)))
		else note_failure("vertex data beat wrong");

	algorithm_data_routed: assert property (@(posedge clock) disable iff (!rstn)
		(algorithm_data_valid == $past(data_for_algorithm, 2))
		&& (algorithm_data == ($past(data_for_algorithm, 2) ? $past(read_data, 2) : '0)))
		else note_failure("algorithm data beat wrong");

	status_matches: assert property (@(posedge clock) disable iff (!rstn)
		algorithm_status == $past(status_now, 2))
		else note_failure($sformatf("algorithm_status %h wrong", algorithm_status));

	running_rises: assert property (@(posedge clock) disable iff (!rstn)
		$past(|algorithm_requests, 2) |-> algorithm_running)
		else note_failure("algorithm_running low after a request mask");

	running_stays: assert property (@(posedge clock) disable iff (!rstn)
		algorithm_running |=> algorithm_running)
		else note_failure("algorithm_running fell");

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic reset_outputs();
		int errors_before;
		errors_before = error_count;
		expect_low(read_command_valid, "read_command_valid");
		expect_low(vertex_cmd_full, "vertex_cmd_full");
		expect_low(algorithm_cmd_full, "algorithm_cmd_full");
		expect_low(vertex_response_valid, "vertex_response_valid");
		expect_low(algorithm_response_valid, "algorithm_response_valid");
		expect_low(vertex_data_valid, "vertex_data_valid");
		expect_low(algorithm_data_valid, "algorithm_data_valid");
		expect_low(|algorithm_status, "algorithm_status");
		expect_low(algorithm_running, "algorithm_running");
		report_test("reset", errors_before);
	endtask

	// read_buffer_alfull is still high from reset, so both queues only fill
	task automatic arbiter_fairness();
		int errors_before;
		int index;
		errors_before = error_count;
		for (index = 0; index < FAIR_DEPTH; index++) begin
			@(posedge clock);
			push_vertex(random_address());
			push_algorithm(random_address());
			@(posedge clock);
			vertex_cmd_valid    <= 1'b0;
			algorithm_cmd_valid <= 1'b0;
		end
		fairness_next_id = VERTEX_CONTROL_ID;
		fairness_seen    = 0;
		fairness_active  = 1'b1;
		@(posedge clock);
		read_buffer_alfull <= 1'b0;
		wait_for_drain();
		fairness_active = 1'b0;
		assert (fairness_seen == 2 * FAIR_DEPTH)
			else note_failure($sformatf("%0d commands left, expected %0d",
				fairness_seen, 2 * FAIR_DEPTH));
		report_test("fairness", errors_before);
	endtask

	task automatic ordered_traffic();
		int errors_before;
		int vertex_left;
		int algorithm_left;
		errors_before  = error_count;
		vertex_left    = TRAFFIC_PUSHES;
		algorithm_left = TRAFFIC_PUSHES;
		while (vertex_left > 0 || algorithm_left > 0) begin
			@(posedge clock);
			read_buffer_alfull <= (($urandom % 4) == 0);
			// never push two cycles running, so the sampled full flag is current
			if (vertex_left > 0 && !vertex_cmd_valid && !vertex_cmd_full
					&& ($urandom % 2) == 1) begin
				push_vertex(random_address());
				vertex_left--;
			end else begin
				vertex_cmd_valid <= 1'b0;
			end
			if (algorithm_left > 0 && !algorithm_cmd_valid && !algorithm_cmd_full
					&& ($urandom % 2) == 1) begin
				push_algorithm(random_address());
				algorithm_left--;
			end else begin
				algorithm_cmd_valid <= 1'b0;
			end
		end
		@(posedge clock);
		vertex_cmd_valid    <= 1'b0;
		algorithm_cmd_valid <= 1'b0;
		read_buffer_alfull  <= 1'b0;
		wait_for_drain();
		report_test("random traffic", errors_before);
	endtask

	task automatic response_routing();
		int errors_before;
		int beat;
		errors_before = error_count;
		for (beat = 0; beat < ROUTING_BEATS; beat++) begin
			@(posedge clock);
			read_response_valid <= (($urandom % 3) != 0);
			read_response_cu_id <= random_cu_id();
			read_data_valid     <= (($urandom % 3) != 0);
			read_data_cu_id     <= random_cu_id();
			read_data           <= {$urandom, $urandom};
		end
		@(posedge clock);
		read_response_valid <= 1'b0;
		read_data_valid     <= 1'b0;
		repeat (4) @(posedge clock);
		report_test("routing", errors_before);
	endtask

	task automatic completion_status();
		int     errors_before;
		int     step;
		count_t filtered;
		errors_before = error_count;
		assert (!algorithm_running)
			else note_failure("algorithm_running high before any request");
		@(posedge clock);
		num_vertices <= 32'd20;
		num_edges    <= 32'd40;
		for (step = 0; step < COMPLETION_STEPS; step++) begin
			@(posedge clock);
			filtered = count_t'($urandom % 21);
			wed_valid             <= (($urandom % 4) != 0);
			vertex_filtered_count <= filtered;
			// about half the steps complete the job
			if (($urandom % 2) == 1) begin
				vertex_done_count <= 32'd20 - filtered;
				edge_done_count   <= 32'd40;
			end else begin
				vertex_done_count <= count_t'($urandom % 21);
				edge_done_count   <= count_t'($urandom % 41);
			end
			if (step == COMPLETION_STEPS / 2) begin
				algorithm_requests <= {$urandom, $urandom} | 64'd1;
			end else begin
				algorithm_requests <= '0;
			end
		end
		repeat (4) @(posedge clock);
		assert (algorithm_running) else note_failure("algorithm_running never rose");
		report_test("completion", errors_before);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		seed_value            = $urandom(24);
		error_count           = 0;
		tests_run             = 0;
		tests_passed          = 0;
		fairness_active       = 1'b0;
		fairness_next_id      = VERTEX_CONTROL_ID;
		fairness_seen         = 0;
		vertex_cmd_valid      = 1'b0;
		vertex_cmd_address    = '0;
		vertex_cmd_cu_id      = '0;
		algorithm_cmd_valid   = 1'b0;
		algorithm_cmd_address = '0;
		algorithm_cmd_cu_id   = '0;
		read_buffer_alfull    = 1'b1;
		read_response_valid   = 1'b0;
		read_response_cu_id   = '0;
		read_data_valid       = 1'b0;
		read_data_cu_id       = '0;
		read_data             = '0;
		wed_valid             = 1'b0;
		num_vertices          = '0;
		num_edges             = '0;
		vertex_filtered_count = '0;
		vertex_done_count     = '0;
		edge_done_count       = '0;
		algorithm_requests    = '0;
		wait (rstn === 1'b1);
		@(posedge clock);
		reset_outputs();
		arbiter_fairness();
		ordered_traffic();
		response_routing();
		completion_status();
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_passed, tests_run - tests_passed, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
source/cu_pkg.sv
source/sync_fifo.sv
source/read_command_arbiter.sv
source/response_router.sv
source/completion_monitor.sv
source/cu_control_top.sv
testbench/clock_gen.sv
testbench/tb_cu_control.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cu_control
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
